// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
source/fetch_pkg.sv
source/icache_fill_if.sv
source/fetch_pc.sv
source/fetch_ctrl.sv
source/refill_counter.sv
source/icache_array.sv
source/fetch_reg.sv
source/fetch_top.sv
testbench/tb_mem_responder.sv
testbench/tb_fetch.sv

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; #(
    parameter int LINES = 8
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        flush,
    input  logic        hit,
    input  addr_t       pc,
    output logic        advance,
    output logic        mem_req,
    output addr_t       mem_addr,
    input  logic        mem_ack,
    input  word_t       mem_data,
    input  word_sel_t   word_sel,
    input  logic        last_word,
    output logic        count_step,
    output logic        count_clear,
    icache_fill_if.ctrl fill
);

    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int IDX_W  = $clog2(LINES);
    localparam int LINE_W = $bits(addr_t) - OFF_W;
    localparam int TAG_W  = LINE_W - IDX_W;

    fetch_state_t      state;
    fetch_state_t      state_nxt;
    // line address of the refill, PC without the offset bits
    logic [LINE_W-1:0] line_addr;
    // word caught on the first ack cycle, written on release
    word_t             fill_data;
    logic              start_fill;

    // new refill only from LOOKUP on a clean miss
    // a flushed PC is about to be replaced, so skip it
    assign start_fill = (state == LOOKUP) && !hit && !stall && !flush;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= LOOKUP;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (start_fill) begin
                    state_nxt = REQ;
                end
            end
            REQ: begin
                if (mem_ack) begin
                    state_nxt = REL;
                end
            end
            // wait for ack low before the next transfer
            REL: begin
                if (!mem_ack) begin
                    state_nxt = last_word ? FILL_DONE : REQ;
                end
            end
            FILL_DONE: state_nxt = LOOKUP;
            default: state_nxt = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            line_addr <= pc[$bits(addr_t)-1:OFF_W];
        end
        if (state == REQ && mem_ack) begin
            fill_data <= mem_data;
        end
    end

    // hit only counts in LOOKUP, a refill freezes the PC
    assign advance = (state == LOOKUP) && hit && !stall && !flush;

    // four-phase request, words from the line base upward
    assign mem_req  = (state == REQ);
    assign mem_addr = {line_addr, word_sel, 2'b00};

    assign count_clear = start_fill;
    // one step per completed transfer
    assign count_step  = (state == REL) && !mem_ack;

    // write lands as the handshake closes
    // so the last word is right before line_done
    assign fill.wr_en     = count_step;
    assign fill.wr_word   = word_sel;
    assign fill.wr_data   = fill_data;
    assign fill.wr_index  = line_addr[IDX_W-1:0];
    assign fill.wr_tag    = line_addr[LINE_W-1 -: TAG_W];
    assign fill.line_done = (state == FILL_DONE);

    // request and its address held until the responder acks
    a_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr))
    );

    // a new transfer opens only once ack was seen low
    a_req_low: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(mem_req) |-> !$past(mem_ack)
    );

endmodule

// ==== source/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc import fetch_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  addr_t redirect_pc,
    input  logic  advance,
    output addr_t pc
);

    addr_t pc_step;

    // aligned PC fetches a full pair, skip both words
    // PC at 8k+4 only gets one insn, so step by one word
    always_comb begin
        if (pc[2]) begin
            pc_step = pc + addr_t'(4);
        end else begin
            pc_step = pc + addr_t'(8);
        end
    end

    // flush wins over a step
    // no advance means miss, stall or refill, so just hold
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (advance) begin
            pc <= pc_step;
        end
    end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // byte address as seen by the fetch PC and the memory port
    typedef logic [31:0] addr_t;

    // one instruction, or one word on the memory bus
    typedef logic [31:0] word_t;

    // instruction pair
    // upper half is the insn at PC, lower half the insn at PC+4
    typedef logic [63:0] pair_t;

    // word position within a cache line
    typedef logic [1:0] word_sel_t;

    // line geometry
    localparam int LINE_WORDS = 4;
    localparam int LINE_BYTES = LINE_WORDS * 4;

    // no-op, fills the second slot when only one insn is fetched
    // andi r0, r0, 0
    localparam word_t NOP_INSN = 32'h0340_0000;

    // refill FSM states
    // LOOKUP     normal fetch, waits for hit or starts a refill
    // REQ        mem_req high, waiting for mem_ack
    // REL        mem_req low, waiting for mem_ack to drop
    // FILL_DONE  one cycle, marks the line valid
    typedef enum logic [1:0] {
        LOOKUP,
        REQ,
        REL,
        FILL_DONE
    } fetch_state_t;

endpackage

// ==== source/fetch_reg.sv ====
`timescale 1ns/1ps

module fetch_reg import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  stall,
    input  logic  hit,
    input  addr_t pc_in,
    input  pair_t pair_in,
    input  logic  flag_in,
    output logic  icache_valid,
    output addr_t pc_out,
    output pair_t ir,
    output logic  flag
);

    // output stage toward decode
    // flush clears everything on the next edge, even under stall
    // otherwise load unless stalled
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            icache_valid <= 1'b0;
            pc_out       <= '0;
            ir           <= '0;
            flag         <= 1'b0;
        end else if (flush) begin
            icache_valid <= 1'b0;
            pc_out       <= '0;
            ir           <= '0;
            flag         <= 1'b0;
        end else if (!stall) begin
            // valid follows the hit seen this cycle
            icache_valid <= hit;
            pc_out       <= pc_in;
            ir           <= pair_in;
            flag         <= flag_in;
        end
    end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int    LINES    = 8,
    parameter addr_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  flush,
    input  logic  stall,
    input  addr_t redirect_pc,
    output logic  icache_valid,
    output addr_t pc_out,
    output pair_t ir,
    output logic  flag,
    output logic  mem_req,
    output addr_t mem_addr,
    input  logic  mem_ack,
    input  word_t mem_data
);

    addr_t     pc;
    logic      hit;
    logic      advance;
    pair_t     pair;
    logic      pair_flag;
    word_sel_t word_sel;
    logic      last_word;
    logic      count_step;
    logic      count_clear;

    // fill path from the refill FSM into the cache
    icache_fill_if #(.LINES(LINES)) fill_bus ();

    fetch_pc #(.RESET_PC(RESET_PC)) u_pc (
        .clk, .rstn, .flush, .redirect_pc, .advance, .pc
    );

    fetch_ctrl #(.LINES(LINES)) u_ctrl (
        .clk, .rstn, .stall, .flush, .hit, .pc, .advance,
        .mem_req, .mem_addr, .mem_ack, .mem_data,
        .word_sel, .last_word, .count_step, .count_clear,
        .fill(fill_bus.ctrl)
    );

    refill_counter u_cnt (
        .clk, .rstn, .count_clear, .count_step, .word_sel, .last_word
    );

    icache_array #(.LINES(LINES)) u_array (
        .clk, .rstn, .pc, .hit, .pair, .pair_flag, .fill(fill_bus.array)
    );

    // registered valid takes the qualified hit
    // so a hit seen during a refill is not delivered twice
    fetch_reg u_reg (
        .clk, .rstn, .flush, .stall, .hit(advance),
        .pc_in(pc), .pair_in(pair), .flag_in(pair_flag),
        .icache_valid, .pc_out, .ir, .flag
    );

endmodule

// ==== source/icache_array.sv ====
`timescale 1ns/1ps

module icache_array import fetch_pkg::*; #(
    parameter int LINES = 8
) (
    input  logic         clk,
    input  logic         rstn,
    input  addr_t        pc,
    output logic         hit,
    output pair_t        pair,
    output logic         pair_flag,
    icache_fill_if.array fill
);

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFF_W;

    // line storage
    word_t            data [LINES][LINE_WORDS];
    logic [TAG_W-1:0] tags [LINES];
    logic [LINES-1:0] valid;

    // PC split into tag, index and word position
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    word_sel_t        wsel;
    word_t            hi_word;
    word_t            lo_word;

    assign idx  = pc[OFF_W +: IDX_W];
    assign tag  = pc[$bits(addr_t)-1 -: TAG_W];
    assign wsel = pc[OFF_W-1:2];

    assign hit = valid[idx] && (tags[idx] == tag);

    // aligned PC has wsel 0 or 2, so wsel+1 stays in the line
    always_comb begin
        hi_word = data[idx][wsel];
        if (!pc[2]) begin
            lo_word   = data[idx][word_sel_t'(wsel + 1'b1)];
            pair_flag = 1'b1;
        end else begin
            lo_word   = NOP_INSN;
            pair_flag = 1'b0;
        end
        pair = {hi_word, lo_word};
    end

    always_ff @(posedge clk) begin
        if (fill.wr_en) begin
            data[fill.wr_index][fill.wr_word] <= fill.wr_data;
        end
        if (fill.line_done) begin
            tags[fill.wr_index] <= fill.wr_tag;
        end
    end

    // a line being overwritten is dropped at its first word
    // and comes back once line_done arrives
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill.line_done) begin
            valid[fill.wr_index] <= 1'b1;
        end else if (fill.wr_en) begin
            valid[fill.wr_index] <= 1'b0;
        end
    end

    // completion follows the last-position write directly
    a_done_after_last: assert property (
        @(posedge clk) disable iff (!rstn)
        fill.line_done |->
            $past(fill.wr_en && fill.wr_word == word_sel_t'(LINE_WORDS - 1))
    );

endmodule

// ==== source/icache_fill_if.sv ====
`timescale 1ns/1ps

interface icache_fill_if import fetch_pkg::*; #(
    parameter int LINES = 8
) ();

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - $clog2(LINE_BYTES);

    // one word written per pulse
    logic             wr_en;
    // target line, stable for the whole refill
    logic [IDX_W-1:0] wr_index;
    // word position inside the line
    word_sel_t        wr_word;
    // tag of the line being filled
    logic [TAG_W-1:0] wr_tag;
    word_t            wr_data;
    // single pulse after the fourth word, sets valid and tag
    logic             line_done;

    // refill control side
    modport ctrl (output wr_en, wr_index, wr_word, wr_tag, wr_data, line_done);

    // cache storage side
    modport array (input wr_en, wr_index, wr_word, wr_tag, wr_data, line_done);

endinterface

// ==== source/refill_counter.sv ====
`timescale 1ns/1ps

module refill_counter import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      count_clear,
    input  logic      count_step,
    output word_sel_t word_sel,
    output logic      last_word
);

    // final word of the line
    assign last_word = (word_sel == word_sel_t'(LINE_WORDS - 1));

    // clear at refill start, step per word
    // wraps to zero after the last word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            word_sel <= '0;
        end else if (count_clear) begin
            word_sel <= '0;
        end else if (count_step) begin
            if (last_word) begin
                word_sel <= '0;
            end else begin
                word_sel <= word_sel + 1'b1;
            end
        end
    end

    // clear is issued in LOOKUP, steps only inside a refill
    a_step_clear: assert property (
        @(posedge clk) disable iff (!rstn)
        !(count_step && count_clear)
    );

endmodule

// ==== testbench/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam int    CLK_PERIOD  = 40;
    localparam int    MAX_DELAY   = 5;
    localparam addr_t START_PC    = 32'h0;
    // worst line refill in cycles, four transfers at full ack and release delay
    localparam int    REFILL_CYC  = LINE_WORDS * (2 * MAX_DELAY + 4) + 2;
    localparam int    FETCHES     = 80;
    localparam int    WATCHDOG_NS = FETCHES * REFILL_CYC * 3 * CLK_PERIOD;

    logic  clk, rstn, flush, stall, icache_valid, flag, mem_req, mem_ack;
    addr_t redirect_pc, pc_out, mem_addr;
    pair_t ir;
    word_t mem_data, rd_data;
    int    violations;

    // scoreboard state
    int    errors      = 0;
    int    failures    = 0;
    int    checks      = 0;
    int    deliveries  = 0;
    int    refills     = 0;
    int    single_slot = 0;
    int    watch_fills = 0;
    int    base;
    addr_t watch_line  = '1;
    addr_t expected_pc = START_PC;
    // inputs as they stood at the last edge, outputs before it
    logic  edge_flush = 1'b0;
    logic  edge_stall = 1'b0;
    logic  req_seen   = 1'b0;
    addr_t edge_redirect;
    addr_t held_pc;
    logic  held_valid;
    logic  held_flag;
    logic  exp_flag;
    pair_t held_ir;
    pair_t exp_ir;

    fetch_top #(.LINES(8), .RESET_PC(START_PC)) DUT (
        .clk, .rstn, .flush, .stall, .redirect_pc, .icache_valid, .pc_out, .ir, .flag,
        .mem_req, .mem_addr, .mem_ack, .mem_data
    );

    tb_mem_responder #(.MAX_DELAY(MAX_DELAY)) u_mem (
        .clk, .rstn, .mem_req, .mem_addr, .rd_data, .mem_ack, .mem_data, .violations
    );

    // memory contents, a multiply and xor mix of the address
    function automatic word_t mem_word(input addr_t a);
        return (a * 32'h2545_f491) ^ (a >> 7) ^ 32'h6b5d_1e07;
    endfunction

    // upper half at pc, lower half at pc+4 or a nop when unaligned
    function automatic void expected_fetch(input addr_t pc, output pair_t pr, output logic flg);
        flg = !pc[2];
        pr  = {mem_word(pc), flg ? mem_word(pc + 32'd4) : NOP_INSN};
    endfunction

    function automatic addr_t next_pc(input addr_t pc);
        return pc[2] ? pc + 32'd4 : pc + 32'd8;
    endfunction

    assign rd_data = mem_word(mem_addr);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (rstn) begin
            // first word of a line marks a refill start
            if (mem_req && !req_seen && mem_addr[3:2] == 2'b00) begin
                refills++;
                if (mem_addr[31:4] == watch_line[31:4]) watch_fills++;
            end
            if (edge_flush) begin
                if (icache_valid) begin
                    errors++;
                    $display("** Error at %0t: icache_valid high after flush", $time);
                end
                expected_pc = edge_redirect;
            end else if (edge_stall) begin
                if (icache_valid !== held_valid || flag !== held_flag ||
                    ir !== held_ir || pc_out !== held_pc) begin
                    errors++;
                    $display("** Error at %0t: outputs changed under stall", $time);
                end
            end else if (icache_valid) begin
                checks++;
                deliveries++;
                expected_fetch(pc_out, exp_ir, exp_flag);
                if (pc_out !== expected_pc) begin
                    errors++;
                    $display("** Error at %0t: pc_out %h, expected %h",
                             $time, pc_out, expected_pc);
                end
                if (ir !== exp_ir || flag !== exp_flag) begin
                    errors++;
                    $display("** Error at %0t: pc %h ir %h flag %b, expected %h flag %b",
                             $time, pc_out, ir, flag, exp_ir, exp_flag);
                end
                if (!flag) single_slot++;
                expected_pc = next_pc(pc_out);
            end
        end
        req_seen      = mem_req;
        held_valid    = icache_valid;
        held_flag     = flag;
        held_ir       = ir;
        held_pc       = pc_out;
        edge_flush    = flush;
        edge_stall    = stall;
        edge_redirect = redirect_pc;
    end

    // one-cycle flush pulse, returns 2 ns after the flush edge
    task automatic flush_to(input addr_t target);
        redirect_pc = target;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
    endtask

    task automatic wait_pairs(input int n);
        int target;
        int cycles;
        target = deliveries + n;
        cycles = 0;
        while (deliveries < target && cycles < (n + 1) * REFILL_CYC * 2) begin
            @(posedge clk);
            cycles++;
        end
        if (deliveries < target) begin
            failures++;
            $display("icache_valid did not come back: %0d of %0d pairs by %0t",
                     n - (target - deliveries), n, $time);
        end
        #2;
    endtask

    // returns on the first word request of a new line
    task automatic wait_refill();
        int cycles;
        cycles = 0;
        while (!(mem_req && mem_addr[3:2] == 2'b00) && cycles < REFILL_CYC * 4) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!(mem_req && mem_addr[3:2] == 2'b00)) begin
            failures++;
            $display("no refill started before the flush-during-refill test");
        end
    endtask

    initial begin
        void'($urandom(12));
        rstn = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        redirect_pc = '0;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        // six lines in order from reset
        wait_pairs(12);
        // replay of cached lines, no memory traffic allowed
        flush_to(32'h0);
        @(posedge clk);
        #2;
        base = refills;
        wait_pairs(12);
        if (refills != base) begin
            failures++;
            $display("refill requested while replaying cached lines");
        end
        // redirect to 8k+4, one insn then aligned pairs
        base = single_slot;
        flush_to(32'h24);
        wait_pairs(4);
        if (single_slot == base) begin
            failures++;
            $display("unaligned redirect never gave a single-slot pair");
        end
        // random stall points
        repeat (40) begin
            stall = ($urandom_range(0, 3) == 0);
            @(posedge clk);
            #2;
        end
        stall = 1'b0;
        wait_pairs(2);
        // flush lands while a line is still filling
        wait_refill();
        repeat ($urandom_range(0, 3)) begin
            @(posedge clk);
            #2;
        end
        flush_to(32'h208);
        wait_pairs(2);
        // index 0 taken by 0x0, then evicted by 0x1000 and back
        flush_to(32'h0);
        wait_pairs(2);
        watch_line = 32'h1000;
        base = watch_fills;
        flush_to(32'h1000);
        wait_pairs(1);
        if (watch_fills != base + 1) begin
            failures++;
            $display("conflicting line 0x1000 was not refilled once");
        end
        watch_line = 32'h0;
        base = watch_fills;
        flush_to(32'h0);
        wait_pairs(1);
        if (watch_fills != base + 1) begin
            failures++;
            $display("evicted line 0x0 was not refilled on return");
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, value errors %0d, other failures %0d, handshake violations %0d",
                 checks, errors, failures, violations);
        if (errors == 0 && failures == 0 && violations == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // bound from planned fetches times the worst refill
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== testbench/tb_mem_responder.sv ====
`timescale 1ns/1ps

module tb_mem_responder import fetch_pkg::*; #(
    parameter int MAX_DELAY = 5
) (
    input  logic  clk,
    input  logic  rstn,
    input  logic  mem_req,
    input  addr_t mem_addr,
    input  word_t rd_data,
    output logic  mem_ack,
    output word_t mem_data,
    output int    violations
);

    addr_t req_addr;
    addr_t next_addr;
    int    delay;

    // four-phase slave, sampled and driven 2 ns after the rising edge
    initial begin
        mem_ack    = 1'b0;
        mem_data   = '0;
        violations = 0;
        next_addr  = '0;
        forever begin
            @(posedge clk);
            #2;
            if (rstn && mem_req) begin
                req_addr = mem_addr;
                if (req_addr[3:2] != 2'b00) begin
                    // later words of a line follow the previous one
                    if (req_addr != next_addr) begin
                        violations++;
                        $display("handshake violation at %0t: word address %h out of order",
                                 $time, req_addr);
                    end
                end else if (next_addr[3:2] != 2'b00) begin
                    // new line only after all four words of the last one
                    violations++;
                    $display("handshake violation at %0t: line left unfinished before %h",
                             $time, req_addr);
                end
                next_addr = req_addr + 32'd4;
                delay = $urandom_range(0, MAX_DELAY);
                // request and address must hold until ack
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                    if (!mem_req || mem_addr != req_addr) begin
                        violations++;
                        $display("handshake violation at %0t: request withdrawn before ack",
                                 $time);
                    end
                end
                mem_data = rd_data;
                mem_ack  = 1'b1;
                // ack stays up until the request is released
                do begin
                    @(posedge clk);
                    #2;
                end while (mem_req);
                // ack lingers a random while after the release
                delay = $urandom_range(0, MAX_DELAY);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                    if (mem_req) begin
                        violations++;
                        $display("handshake violation at %0t: new request while ack still high",
                                 $time);
                    end
                end
                mem_ack = 1'b0;
            end
        end
    end

endmodule
